// ==== hw/tile_pkg.sv ====
/*
 * Shared definitions for the tile fetch engine.
 * Holds the buffer widths, the loader and stream structs, the reader
 * state encoding and the geometry of the input and weight tiles.
 * Design files import it inside the module body.
 */
package tile_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 10;
    localparam int CNT_W     = 8;
    localparam int BUF_DEPTH = 1 << ADDR_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    // loader write into the buffer.
    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } buf_wr_t;

    // one reader's output strobe, no back-pressure.
    typedef struct packed {
        logic  valid;
        word_t data;
    } stream_t;

    typedef enum logic [1:0] {
        IDLE,
        PRIME,
        RUN,
        DRAIN
    } reader_state_t;

    // input feature map tile, 16 words per image row.
    localparam addr_t IN_BASE         = 10'd0;
    localparam cnt_t  IN_COLS         = 8'd4;
    localparam cnt_t  IN_ROWS         = 8'd3;
    localparam cnt_t  IN_PLANES       = 8'd2;
    localparam addr_t IN_ROW_STRIDE   = 10'd16;
    localparam addr_t IN_PLANE_STRIDE = 10'd256;

    // weight tile, packed contiguously at the top of the buffer.
    localparam addr_t WT_BASE         = 10'd768;
    localparam cnt_t  WT_COLS         = 8'd3;
    localparam cnt_t  WT_ROWS         = 8'd3;
    localparam cnt_t  WT_PLANES       = 8'd2;
    localparam addr_t WT_ROW_STRIDE   = 10'd3;
    localparam addr_t WT_PLANE_STRIDE = 10'd9;

endpackage

// ==== hw/nest3_counter.sv ====
/*
 * Three-level nested index counter for tile walks.
 * Index 0 runs fastest and each outer index steps when all inner ones
 * sit at their final value. Reset and syn_rst park every index at its
 * maximum ("not loaded"); the next ena loads zeros.
 */
module nest3_counter #(
    parameter tile_pkg::cnt_t n0_max = 8'd4,
    parameter tile_pkg::cnt_t n1_max = 8'd2,
    parameter tile_pkg::cnt_t n2_max = 8'd2
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           ena,
    input  logic           syn_rst,
    output tile_pkg::cnt_t cnt0,
    output tile_pkg::cnt_t cnt1,
    output tile_pkg::cnt_t cnt2,
    output logic           last
);

    logic full0;
    logic full1;
    logic full2;

    // carry chain, each level full only if all inner levels are full.
    assign full0 = (cnt0 == n0_max - 1'b1);
    assign full1 = full0 && (cnt1 == n1_max - 1'b1);
    assign full2 = full1 && (cnt2 == n2_max - 1'b1);
    assign last  = full2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt0 <= n0_max;
        end else if (syn_rst) begin
            cnt0 <= n0_max;
        end else if (ena) begin
            if (cnt0 == n0_max || full0) begin
                cnt0 <= '0;
            end else begin
                cnt0 <= cnt0 + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt1 <= n1_max;
        end else if (syn_rst) begin
            cnt1 <= n1_max;
        end else if (ena) begin
            if (cnt1 == n1_max || full1) begin
                cnt1 <= '0;
            end else if (full0) begin
                cnt1 <= cnt1 + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt2 <= n2_max;
        end else if (syn_rst) begin
            cnt2 <= n2_max;
        end else if (ena) begin
            if (cnt2 == n2_max || full2) begin
                cnt2 <= '0;
            end else if (full1) begin
                cnt2 <= cnt2 + 1'b1;
            end
        end
    end

    // the parked value is the only one allowed above the final index.
    a_idx_range: assert property (
        @(posedge clk) disable iff (rst)
        cnt0 <= n0_max && cnt1 <= n1_max && cnt2 <= n2_max
    );

endmodule

// ==== hw/tile_buffer.sv ====
/*
 * On-chip feature map and weight store.
 * One write port for the loader and one read port with registered
 * output. A read colliding with a write returns the previous word.
 */
module tile_buffer (
    input  logic              clk,
    input  tile_pkg::buf_wr_t wr,
    input  logic              rd_en,
    input  tile_pkg::addr_t   rd_addr,
    output tile_pkg::word_t   rd_data
);
    import tile_pkg::*;

    word_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read sees the array before this edge's write.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hw/buffer_arbiter.sv ====
/*
 * Round-robin owner of the buffer read port.
 * Grants one of two readers per cycle, drives the winner's address
 * onto the port and steers the read data back one cycle later.
 */
module buffer_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [1:0]            req,
    input  tile_pkg::addr_t [1:0] addr_in,
    output logic [1:0]            gnt,
    output logic                  rd_en,
    output tile_pkg::addr_t       rd_addr,
    input  tile_pkg::word_t       rd_data,
    output logic [1:0]            rvalid,
    output tile_pkg::word_t       rdata
);

    logic win;
    logic rd_id_q;
    logic rd_pend_q;

    // on a tie the reader that lost last time wins.
    always_comb begin
        if (req == 2'b11) begin
            gnt = rd_id_q ? 2'b01 : 2'b10;
        end else begin
            gnt = req;
        end
    end

    assign win     = gnt[1];
    assign rd_en   = |gnt;
    assign rd_addr = addr_in[win];

    // winner id doubles as the round-robin history.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_id_q   <= 1'b1;
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_en;
            if (rd_en) begin
                rd_id_q <= win;
            end
        end
    end

    assign rvalid = {rd_pend_q && rd_id_q, rd_pend_q && !rd_id_q};
    assign rdata  = rd_data;

    a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt));

    a_gnt_req: assert property (@(posedge clk) disable iff (rst) (gnt & ~req) == 2'b00);

endmodule

// ==== hw/tile_reader.sv ====
/*
 * Tile reader. Walks one 3-D tile with a nested counter, requests the
 * shared buffer read port per element and forwards the returned words
 * as a valid strobe. A start at any time restarts the walk.
 */
module tile_reader #(
    parameter tile_pkg::addr_t BASE         = tile_pkg::IN_BASE,
    parameter tile_pkg::cnt_t  COLS         = tile_pkg::IN_COLS,
    parameter tile_pkg::cnt_t  ROWS         = tile_pkg::IN_ROWS,
    parameter tile_pkg::cnt_t  PLANES       = tile_pkg::IN_PLANES,
    parameter tile_pkg::addr_t ROW_STRIDE   = tile_pkg::IN_ROW_STRIDE,
    parameter tile_pkg::addr_t PLANE_STRIDE = tile_pkg::IN_PLANE_STRIDE
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              req,
    output tile_pkg::addr_t   addr,
    input  logic              gnt,
    input  logic              rvalid,
    input  tile_pkg::word_t   rdata,
    output tile_pkg::stream_t stream,
    output logic              busy,
    output logic              done
);
    import tile_pkg::*;

    reader_state_t state;
    reader_state_t state_nxt;
    cnt_t          col;
    cnt_t          row;
    cnt_t          plane;
    logic          last;
    logic          cnt_ena;
    logic          pending;

    // prime loads zeros, each grant steps to the next element.
    assign cnt_ena = (state == PRIME) || gnt;

    nest3_counter #(
        .n0_max (COLS),
        .n1_max (ROWS),
        .n2_max (PLANES)
    ) u_cnt (
        .clk     (clk),
        .rst     (rst),
        .ena     (cnt_ena),
        .syn_rst (start),
        .cnt0    (col),
        .cnt1    (row),
        .cnt2    (plane),
        .last    (last)
    );

    assign addr = BASE + plane * PLANE_STRIDE + row * ROW_STRIDE + col;
    assign req  = (state == RUN);
    assign busy = (state != IDLE);

    always_comb begin
        state_nxt = state;
        if (start) begin
            state_nxt = PRIME;
        end else begin
            case (state)
                PRIME:   state_nxt = RUN;
                RUN:     state_nxt = (gnt && last) ? DRAIN : RUN;
                DRAIN:   state_nxt = IDLE;
                default: state_nxt = state;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            done    <= 1'b0;
            pending <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state == DRAIN) && !start;
            // a restart orphans any word still in flight.
            if (start) begin
                pending <= 1'b0;
            end else if (gnt) begin
                pending <= 1'b1;
            end else if (rvalid) begin
                pending <= 1'b0;
            end
        end
    end

    assign stream.valid = rvalid && pending;
    assign stream.data  = rdata;

    // arbiter sees one address for the whole life of a request.
    a_addr_hold: assert property (
        @(posedge clk) disable iff (rst)
        (req && !gnt && !start) |=> $stable(addr)
    );

endmodule

// ==== hw/tile_fetch_top.sv ====
/*
 * Tile fetch engine top level.
 * Buffer, read port arbiter and the input and weight tile readers.
 * Reader 0 of the arbiter is the input reader, reader 1 the weights.
 */
module tile_fetch_top (
    input  logic              clk,
    input  logic              rst,
    input  tile_pkg::buf_wr_t wr,
    input  logic              start_in,
    input  logic              start_wt,
    output tile_pkg::stream_t in_stream,
    output tile_pkg::stream_t wt_stream,
    output logic              in_busy,
    output logic              wt_busy,
    output logic              in_done,
    output logic              wt_done
);
    import tile_pkg::*;

    logic [1:0] req;
    logic [1:0] gnt;
    logic [1:0] rvalid;
    addr_t      in_addr;
    addr_t      wt_addr;
    addr_t      rd_addr;
    logic       rd_en;
    word_t      rd_data;
    word_t      rdata;

    tile_buffer u_buffer (
        .clk     (clk),
        .wr      (wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    buffer_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .addr_in ({wt_addr, in_addr}),
        .gnt     (gnt),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rvalid  (rvalid),
        .rdata   (rdata)
    );

    tile_reader #(
        .BASE         (IN_BASE),
        .COLS         (IN_COLS),
        .ROWS         (IN_ROWS),
        .PLANES       (IN_PLANES),
        .ROW_STRIDE   (IN_ROW_STRIDE),
        .PLANE_STRIDE (IN_PLANE_STRIDE)
    ) u_in_reader (
        .clk    (clk),
        .rst    (rst),
        .start  (start_in),
        .req    (req[0]),
        .addr   (in_addr),
        .gnt    (gnt[0]),
        .rvalid (rvalid[0]),
        .rdata  (rdata),
        .stream (in_stream),
        .busy   (in_busy),
        .done   (in_done)
    );

    tile_reader #(
        .BASE         (WT_BASE),
        .COLS         (WT_COLS),
        .ROWS         (WT_ROWS),
        .PLANES       (WT_PLANES),
        .ROW_STRIDE   (WT_ROW_STRIDE),
        .PLANE_STRIDE (WT_PLANE_STRIDE)
    ) u_wt_reader (
        .clk    (clk),
        .rst    (rst),
        .start  (start_wt),
        .req    (req[1]),
        .addr   (wt_addr),
        .gnt    (gnt[1]),
        .rvalid (rvalid[1]),
        .rdata  (rdata),
        .stream (wt_stream),
        .busy   (wt_busy),
        .done   (wt_done)
    );

endmodule

// ==== dv/tile_fetch_tb.sv ====
/*
 * Directed testbench for the tile fetch engine.
 * Fills the buffer from a seeded random source, runs the input and
 * weight readers alone, together and with a restart, and compares the
 * streamed words with an address walk over a mirror of the buffer.
 */
module tile_fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import tile_pkg::*;

    localparam int IN_WORDS = int'(IN_COLS) * int'(IN_ROWS) * int'(IN_PLANES);
    localparam int WT_WORDS = int'(WT_COLS) * int'(WT_ROWS) * int'(WT_PLANES);
    localparam int RESTART_AT = 10;
    // sum of the words that all six tests expect to stream.
    localparam int TOTAL_WORDS = 3 * IN_WORDS + 3 * WT_WORDS + RESTART_AT;
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_WORDS + BUF_DEPTH + 64;

    logic    clk;
    logic    rst;
    buf_wr_t wr;
    logic    start_in;
    logic    start_wt;
    stream_t in_stream;
    stream_t wt_stream;
    logic    in_busy;
    logic    wt_busy;
    logic    in_done;
    logic    wt_done;

    word_t mirror [BUF_DEPTH];
    word_t in_q[$];
    word_t wt_q[$];
    int    in_dones;
    int    wt_dones;
    int    seed = 23877;
    int    mismatch_errs = 0;
    int    other_errs = 0;

    tile_fetch_top DUT (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .start_in  (start_in),
        .start_wt  (start_wt),
        .in_stream (in_stream),
        .wt_stream (wt_stream),
        .in_busy   (in_busy),
        .wt_busy   (wt_busy),
        .in_done   (in_done),
        .wt_done   (wt_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string test, input word_t exp, input word_t act);
        if (act !== exp) begin
            mismatch_errs++;
            $display("mismatch %s: expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_errs++;
            $display("mismatch %s: expected %0b actual %0b", test, exp, act);
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        if (act != exp) begin
            mismatch_errs++;
            $display("mismatch %s: expected %0d actual %0d", test, exp, act);
        end
    endtask

    task automatic load_buffer();
        for (int i = 0; i < BUF_DEPTH; i++) begin
            @(negedge clk);
            wr.en   = 1'b1;
            wr.addr = addr_t'(i);
            wr.data = word_t'($random(seed));
            mirror[i] = wr.data;
        end
        @(negedge clk);
        wr = '0;
    endtask

    // starts the chosen readers and gathers both streams until each done.
    task automatic collect(input string test, input bit run_in, input bit run_wt,
                           input int restart_at);
        int            cycles;
        int            limit;
        int            tail;
        bit            restarted;
        reader_state_t st;
        limit = 40 * (int'(run_in) * (IN_WORDS + restart_at) + int'(run_wt) * WT_WORDS);
        cycles = 0;
        tail = 0;
        restarted = 1'b0;
        in_q.delete();
        wt_q.delete();
        in_dones = 0;
        wt_dones = 0;
        @(negedge clk);
        start_in = run_in;
        start_wt = run_wt;
        while (tail < 4) begin
            @(negedge clk);
            start_in = 1'b0;
            start_wt = 1'b0;
            if (cycles == 0) begin
                // reader is in prime here.
                if (run_in) check_flag({test, " in_busy"}, 1'b1, in_busy);
                if (run_wt) check_flag({test, " wt_busy"}, 1'b1, wt_busy);
            end
            cycles++;
            if (in_stream.valid) in_q.push_back(in_stream.data);
            if (wt_stream.valid) wt_q.push_back(wt_stream.data);
            if (in_done) in_dones++;
            if (wt_done) wt_dones++;
            // words before the restart stand but are not part of the new tile.
            if (restart_at > 0 && !restarted && in_q.size() == restart_at) begin
                start_in = 1'b1;
                in_q.delete();
                restarted = 1'b1;
            end
            if ((!run_in || in_dones > 0) && (!run_wt || wt_dones > 0)) begin
                tail++;
            end else if (cycles > limit) begin
                other_errs++;
                st = DUT.u_in_reader.state;
                $display("%s: a done pulse did not arrive within %0d cycles, input reader in %s",
                         test, limit, st.name());
                break;
            end
        end
        if (run_in) check_count({test, " in_done pulses"}, 1, in_dones);
        if (run_wt) check_count({test, " wt_done pulses"}, 1, wt_dones);
        check_flag({test, " in_busy after"}, 1'b0, in_busy);
        check_flag({test, " wt_busy after"}, 1'b0, wt_busy);
    endtask

    // expected stream is the column, row, plane walk over the mirror.
    task automatic compare_tile(input string test, input bit is_wt);
        word_t got[$];
        word_t exp[$];
        int    base;
        int    cols;
        int    rows;
        int    planes;
        int    rs;
        int    ps;
        if (is_wt) begin
            got = wt_q;
            base = int'(WT_BASE);
            cols = int'(WT_COLS);
            rows = int'(WT_ROWS);
            planes = int'(WT_PLANES);
            rs = int'(WT_ROW_STRIDE);
            ps = int'(WT_PLANE_STRIDE);
        end else begin
            got = in_q;
            base = int'(IN_BASE);
            cols = int'(IN_COLS);
            rows = int'(IN_ROWS);
            planes = int'(IN_PLANES);
            rs = int'(IN_ROW_STRIDE);
            ps = int'(IN_PLANE_STRIDE);
        end
        for (int p = 0; p < planes; p++) begin
            for (int r = 0; r < rows; r++) begin
                for (int c = 0; c < cols; c++) begin
                    exp.push_back(mirror[addr_t'(base + p * ps + r * rs + c)]);
                end
            end
        end
        check_count({test, " words"}, exp.size(), got.size());
        for (int i = 0; i < exp.size() && i < got.size(); i++) begin
            check_word($sformatf("%s word %0d", test, i), exp[i], got[i]);
        end
    endtask

    task automatic test_reset();
        check_flag("reset in_valid", 1'b0, in_stream.valid);
        check_flag("reset wt_valid", 1'b0, wt_stream.valid);
        check_flag("reset in_busy", 1'b0, in_busy);
        check_flag("reset wt_busy", 1'b0, wt_busy);
        check_flag("reset in_done", 1'b0, in_done);
        check_flag("reset wt_done", 1'b0, wt_done);
    endtask

    task automatic test_input_alone();
        collect("input_alone", 1'b1, 1'b0, 0);
        compare_tile("input_alone", 1'b0);
    endtask

    task automatic test_weight_alone();
        collect("weight_alone", 1'b0, 1'b1, 0);
        compare_tile("weight_alone", 1'b1);
    endtask

    task automatic test_both();
        collect("both", 1'b1, 1'b1, 0);
        compare_tile("both input", 1'b0);
        compare_tile("both weight", 1'b1);
    endtask

    task automatic test_restart();
        collect("restart", 1'b1, 1'b0, RESTART_AT);
        compare_tile("restart", 1'b0);
    endtask

    task automatic test_write_idle();
        addr_t targets [3];
        targets = '{WT_BASE, WT_BASE + 10'd7, WT_BASE + 10'd17};
        foreach (targets[i]) begin
            @(negedge clk);
            wr.en   = 1'b1;
            wr.addr = targets[i];
            wr.data = word_t'($random(seed));
            mirror[targets[i]] = wr.data;
        end
        @(negedge clk);
        wr = '0;
        collect("write_idle", 1'b0, 1'b1, 0);
        compare_tile("write_idle", 1'b1);
    endtask

    initial begin
        rst = 1'b1;
        wr = '0;
        start_in = 1'b0;
        start_wt = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset();
        load_buffer();
        test_input_alone();
        test_weight_alone();
        test_both();
        test_restart();
        test_write_idle();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/tile_pkg.sv
hw/nest3_counter.sv
hw/tile_buffer.sv
hw/buffer_arbiter.sv
hw/tile_reader.sv
hw/tile_fetch_top.sv
dv/tile_fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the tile fetch engine testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f verilog.f \
    --top-module tile_fetch_tb \
    --Mdir obj_dir \
    -o tile_fetch_sim

./obj_dir/tile_fetch_sim | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
